//--- design/wt_cache_config.svh
`ifndef WT_CACHE_CONFIG_SVH
`define WT_CACHE_CONFIG_SVH

// byte address width on both sides
`define WT_ADDR_W 32

// processor side word
`define WT_FE_DATA_W 32

// memory side word
// must be a power-of-two multiple of the processor word
`define WT_BE_DATA_W 128

// write buffer entries
// keep this a power of two so the pointers wrap on their own
`define WT_WB_DEPTH 4

`endif

//--- design/wt_cache_pkg.sv
`include "wt_cache_config.svh"

package wt_cache_pkg;

   localparam int FE_NBYTES = `WT_FE_DATA_W / 8;
   localparam int BE_NBYTES = `WT_BE_DATA_W / 8;
   localparam int NLANES    = `WT_BE_DATA_W / `WT_FE_DATA_W;  // processor words per memory word
   localparam int LANE_W    = $clog2(NLANES);
   localparam int FE_OFF_W  = $clog2(FE_NBYTES);  // byte offset inside a processor word
   localparam int FE_ADDR_W = `WT_ADDR_W - FE_OFF_W;

   // one word addressed processor write
   typedef struct packed {
      logic [FE_ADDR_W-1:0]     addr;
      logic [`WT_FE_DATA_W-1:0] wdata;
      logic [FE_NBYTES-1:0]     wstrb;
   } fe_req_t;

   // memory word as flat bits or as processor sized lanes
   typedef union packed {
      logic [`WT_BE_DATA_W-1:0]             raw;
      logic [NLANES-1:0][`WT_FE_DATA_W-1:0] lanes;
   } be_data_u;

   // one memory write at a byte address with the low bits zero
   typedef struct packed {
      logic [`WT_ADDR_W-1:0] addr;
      be_data_u              wdata;
      logic [BE_NBYTES-1:0]  wstrb;
   } be_req_t;

endpackage

//--- design/wt_write_buffer.sv
`timescale 1ns/1ps

`include "wt_cache_config.svh"

module wt_write_buffer (
   input  logic                  clk_i,
   input  logic                  reset,

   input  logic                  push,
   input  wt_cache_pkg::fe_req_t push_req,
   output logic                  full,

   input  logic                  pop,
   output wt_cache_pkg::fe_req_t head_req,
   output logic                  not_empty
);

   import wt_cache_pkg::*;

   localparam int DEPTH = `WT_WB_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   fe_req_t          entries [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;  // one extra bit to tell full from empty
   logic             do_push;
   logic             do_pop;

   generate
      if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
         $error("write buffer depth must be a power of two of at least 2");
      end
   endgenerate

   assign do_pop  = pop & not_empty;
   assign do_push = push & (~full | do_pop);  // a full buffer takes a word only as one leaves

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;  // both or neither
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         entries[wr_ptr] <= push_req;
      end
   end

   assign head_req  = entries[rd_ptr];
   assign not_empty = (count != '0);
   assign full      = (count == (PTR_W + 1)'(DEPTH));

   // the channel must only take a word it has seen
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset)
      pop |-> not_empty)
      else $error("write buffer popped while empty");

   a_count_max: assert property (@(posedge clk_i) disable iff (reset)
      count <= (PTR_W + 1)'(DEPTH))
      else $error("write buffer holds more than %0d entries", DEPTH);

endmodule

//--- design/wt_write_channel.sv
`timescale 1ns/1ps

module wt_write_channel (
   input  logic                  clk_i,
   input  logic                  reset,

   input  logic                  req_valid,
   input  wt_cache_pkg::fe_req_t req,
   output logic                  req_pop,

   output logic                  be_valid,
   output wt_cache_pkg::be_req_t be_req,
   input  logic                  be_ready
);

   import wt_cache_pkg::*;

   localparam logic st_idle  = 1'b0;
   localparam logic st_write = 1'b1;

   logic                 state;
   logic                 state_nxt;
   fe_req_t              held_req;
   logic [LANE_W-1:0]    lane;
   logic [BE_NBYTES-1:0] strb_ext;

   generate
      if (NLANES < 2 || (NLANES & (NLANES - 1)) != 0) begin : g_bad_ratio
         $error("memory word must be a power-of-two multiple of the processor word");
      end
   endgenerate

   assign be_valid = (state == st_write);

   // idle takes the head at once
   // write takes the next one on the completing edge
   assign req_pop = req_valid & (~be_valid | be_ready);

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (req_valid) begin
               state_nxt = st_write;
            end
         end
         default: begin
            if (be_ready && !req_valid) begin
               state_nxt = st_idle;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_pop) begin
         held_req <= req;
      end
   end

   assign lane     = held_req.addr[LANE_W-1:0];
   assign strb_ext = {{(BE_NBYTES - FE_NBYTES){1'b0}}, held_req.wstrb};

   always_comb begin
      // drop lane and byte offset bits
      be_req.addr = {held_req.addr[FE_ADDR_W-1:LANE_W], {(LANE_W + FE_OFF_W){1'b0}}};
      for (int i = 0; i < NLANES; i++) begin
         be_req.wdata.lanes[i] = held_req.wdata;  // same word in every lane
      end
      be_req.wstrb = strb_ext << (lane * FE_NBYTES);  // only the addressed lane is written
   end

   a_be_req_stable: assert property (@(posedge clk_i) disable iff (reset)
      be_valid && !be_ready |=> be_valid && $stable(be_req))
      else $error("back-end request changed while stalled");

   // the processor never sends an empty strobe
   a_be_wstrb_set: assert property (@(posedge clk_i) disable iff (reset)
      be_valid |-> be_req.wstrb != '0)
      else $error("back-end write with no strobe bits");

   a_pop_to_write: assert property (@(posedge clk_i) disable iff (reset)
      req_pop |-> req_valid ##1 be_valid)
      else $error("popped word was not presented to the back end");

endmodule

//--- design/wt_write_path.sv
`timescale 1ns/1ps

module wt_write_path (
   input  logic                  clk_i,
   input  logic                  reset,

   // processor side
   input  logic                  fe_valid,
   input  wt_cache_pkg::fe_req_t fe_req,
   output logic                  fe_ready,

   // memory side
   output logic                  be_valid,
   output wt_cache_pkg::be_req_t be_req,
   input  logic                  be_ready
);

   import wt_cache_pkg::*;

   logic    full;
   logic    push;
   logic    wb_valid;
   logic    wb_pop;
   fe_req_t wb_req;

   assign fe_ready = ~full;  // independent of fe_valid
   assign push     = fe_valid & fe_ready;

   wt_write_buffer buffer_i (
      .clk_i     (clk_i),
      .reset     (reset),
      .push      (push),
      .push_req  (fe_req),
      .full      (full),
      .pop       (wb_pop),
      .head_req  (wb_req),
      .not_empty (wb_valid)
   );

   wt_write_channel channel_i (
      .clk_i     (clk_i),
      .reset     (reset),
      .req_valid (wb_valid),
      .req       (wb_req),
      .req_pop   (wb_pop),
      .be_valid  (be_valid),
      .be_req    (be_req),
      .be_ready  (be_ready)
   );

endmodule

//--- tests/tb_wt_write_path_tests.svh
`ifndef TB_WT_WRITE_PATH_TESTS_SVH
`define TB_WT_WRITE_PATH_TESTS_SVH

task automatic test_reset_state();
   int errs_before;
   int writes_before;
   errs_before   = error_count;
   writes_before = writes_done;
   check_ready("be_valid", be_valid, 1'b0);
   check_ready("fe_ready", fe_ready, 1'b1);
   send_write(make_req(32'h0000_1000, 32'hdead_beef, '1));  // lane 0
   wait_drain("reset state");
   check_count("writes done", writes_done - writes_before, 1);
   report_test("reset_state", errs_before);
endtask

task automatic test_lane_align();
   int                    errs_before;
   logic [`WT_ADDR_W-1:0] base;
   errs_before = error_count;
   base        = 32'h8000_4a30;  // lane bits zero
   for (int lane = 0; lane < NLANES; lane++) begin
      send_write(make_req(base + lane * FE_NBYTES, 32'hc0de_0a00 + lane * 32'h0101_0101, '1));
   end
   wait_drain("lane alignment");
   report_test("lane_align", errs_before);
endtask

task automatic test_partial_strobes();
   int                   errs_before;
   logic [FE_NBYTES-1:0] strbs [6];
   int                   lanes [6];
   errs_before = error_count;
   strbs       = '{4'b0001, 4'b0100, 4'b1100, 4'b0110, 4'b1000, 4'b0011};
   lanes       = '{1, 2, 3, 0, 3, 1};
   for (int i = 0; i < 6; i++) begin
      send_write(make_req(32'h0004_0100 + lanes[i] * FE_NBYTES + i * BE_NBYTES,
                          32'h8421_7e00 + i, strbs[i]));
      if (i == 2) begin
         wait_drain("partial strobes");  // one lone write among the stream
      end
   end
   wait_drain("partial strobes");
   report_test("partial_strobes", errs_before);
endtask

task automatic test_back_pressure();
   int errs_before;
   int writes_before;
   int accepted;
   errs_before   = error_count;
   writes_before = writes_done;
   set_ready_mode(READY_LOW);
   accepted = 0;
   while (fe_ready && accepted < `WT_WB_DEPTH + 3) begin
      send_write(make_req(32'h0010_0000 + accepted * FE_NBYTES, 32'h5500_00a0 + accepted, '1));
      accepted++;
   end
   // one word held in the channel and a full buffer behind it
   check_count("accepted writes", accepted, `WT_WB_DEPTH + 1);
   check_ready("fe_ready", fe_ready, 1'b0);
   check_ready("be_valid", be_valid, 1'b1);
   check_be_req("be_req stalled", be_req, exp_q[0]);
   repeat (6) @(negedge clk_i);
   check_be_req("be_req stalled", be_req, exp_q[0]);
   check_ready("fe_ready", fe_ready, 1'b0);
   check_count("writes during stall", writes_done - writes_before, 0);
   set_ready_mode(READY_HIGH);
   wait_drain("back-pressure");
   check_count("writes after release", writes_done - writes_before, accepted);
   report_test("back_pressure", errs_before);
endtask

task automatic test_random_stalls();
   int                    errs_before;
   int                    writes_before;
   logic [`WT_ADDR_W-1:0] rnd_addr;
   logic [31:0]           rnd_data;
   logic [31:0]           rnd_strb;
   logic [FE_NBYTES-1:0]  strb;
   errs_before   = error_count;
   writes_before = writes_done;
   set_ready_mode(READY_RANDOM);
   for (int i = 0; i < 40; i++) begin
      rnd_addr = $random(seed);
      rnd_data = $random(seed);
      rnd_strb = $random(seed);
      strb     = rnd_strb[FE_NBYTES-1:0];
      if (strb == '0) begin
         strb = '1;  // processor never sends an empty strobe
      end
      send_write(make_req(rnd_addr, rnd_data, strb));
      if (rnd_strb[8]) begin
         @(negedge clk_i);  // gap on the front end now and then
      end
   end
   wait_drain("random stalls");
   set_ready_mode(READY_HIGH);
   check_count("expected queue", exp_q.size(), 0);
   check_count("random writes", writes_done - writes_before, 40);
   report_test("random_stalls", errs_before);
endtask

`endif

//--- tests/tb_wt_write_path.sv
`timescale 1ns/1ps

`include "wt_cache_config.svh"

module tb_wt_write_path;

   import wt_cache_pkg::*;

   localparam int WAIT_LIMIT  = 500;  // cycles per wait loop
   localparam int WATCHDOG_NS = 400_000;

   localparam int READY_HIGH   = 0;
   localparam int READY_LOW    = 1;
   localparam int READY_RANDOM = 2;

   logic    clk_i;
   logic    reset;
   logic    fe_valid;
   fe_req_t fe_req;
   logic    fe_ready;
   logic    be_valid;
   be_req_t be_req;
   logic    be_ready;

   integer  seed;
   int      ready_mode;
   logic    ready_next;
   be_req_t exp_q [$];
   be_req_t exp_head;
   int      error_count;
   int      check_total;
   int      writes_done;
   int      tests_run;

   wt_write_path dut_i (
      .clk_i    (clk_i),
      .reset    (reset),
      .fe_valid (fe_valid),
      .fe_req   (fe_req),
      .fe_ready (fe_ready),
      .be_valid (be_valid),
      .be_req   (be_req),
      .be_ready (be_ready)
   );

   always #10 clk_i = ~clk_i;

   // memory responder picks its level at the rising edge
   always @(posedge clk_i) begin
      case (ready_mode)
         READY_HIGH: ready_next <= 1'b1;
         READY_LOW:  ready_next <= 1'b0;
         default:    ready_next <= 1'($random(seed));
      endcase
   end

   always @(negedge clk_i) begin
      be_ready = ready_next;
   end

   // each completed memory write against the oldest prediction
   always @(posedge clk_i) begin
      if (!reset && be_valid && be_ready) begin
         writes_done++;
         if (exp_q.size() == 0) begin
            $display("[%0t] back-end write to %h with nothing expected", $time, be_req.addr);
            error_count++;
         end else begin
            exp_head = exp_q.pop_front();
            check_be_req("be_req", be_req, exp_head);
         end
      end
   end

   task automatic check_be_req(input string name, input be_req_t got, input be_req_t exp);
      check_total++;
      if (got.addr !== exp.addr) begin
         $display("Mismatch %s.addr: got %h expected %h", name, got.addr, exp.addr);
         error_count++;
      end
      if (got.wdata.raw !== exp.wdata.raw) begin
         $display("Mismatch %s.wdata: got %h expected %h", name, got.wdata.raw, exp.wdata.raw);
         error_count++;
      end
      if (got.wstrb !== exp.wstrb) begin
         $display("Mismatch %s.wstrb: got %h expected %h", name, got.wstrb, exp.wstrb);
         error_count++;
      end
   endtask

   task automatic check_ready(input string name, input logic got, input logic exp);
      check_total++;
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      check_total++;
      if (got != exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   function automatic fe_req_t make_req(input logic [`WT_ADDR_W-1:0]    byte_addr,
                                        input logic [`WT_FE_DATA_W-1:0] data,
                                        input logic [FE_NBYTES-1:0]     strb);
      fe_req_t r;
      r.addr  = byte_addr[`WT_ADDR_W-1:FE_OFF_W];
      r.wdata = data;
      r.wstrb = strb;
      return r;
   endfunction

   // memory write that one processor write should become
   function automatic be_req_t predict_be(input fe_req_t r);
      be_req_t               p;
      logic [`WT_ADDR_W-1:0] byte_addr;
      int                    lane;
      byte_addr   = {r.addr, {FE_OFF_W{1'b0}}};
      lane        = int'(byte_addr % BE_NBYTES) / FE_NBYTES;
      p.addr      = byte_addr - (byte_addr % BE_NBYTES);  // start of the memory word
      p.wdata.raw = {NLANES{r.wdata}};
      p.wstrb     = '0;
      for (int b = 0; b < FE_NBYTES; b++) begin
         p.wstrb[lane * FE_NBYTES + b] = r.wstrb[b];
      end
      return p;
   endfunction

   // starts at a falling edge, returns at the falling edge after the transfer
   task automatic send_write(input fe_req_t r);
      int waited;
      waited   = 0;
      fe_valid = 1'b1;
      fe_req   = r;
      while (!fe_ready && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!fe_ready) begin
         $display("[%0t] timeout: front end never took the write to %h", $time, r.addr);
         error_count++;
      end else begin
         exp_q.push_back(predict_be(r));
         @(negedge clk_i);
      end
      fe_valid = 1'b0;
   endtask

   task automatic wait_drain(input string what);
      int waited;
      waited = 0;
      while ((exp_q.size() != 0 || be_valid) && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (exp_q.size() != 0 || be_valid) begin
         $display("[%0t] timeout: %s left %0d writes unfinished", $time, what, exp_q.size());
         error_count++;
      end
   endtask

   // new level is on be_ready from the next rising edge on
   task automatic set_ready_mode(input int mode);
      ready_mode = mode;
      @(negedge clk_i);
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      $display("test %-16s %s, %0d errors", name,
               (error_count == errs_before) ? "ok" : "failed", error_count - errs_before);
   endtask

   `include "tb_wt_write_path_tests.svh"

   initial begin
      clk_i       = 1'b0;
      reset       = 1'b1;
      fe_valid    = 1'b0;
      fe_req      = '0;
      be_ready    = 1'b0;
      ready_next  = 1'b1;
      ready_mode  = READY_HIGH;
      seed        = 32'h47a26785;
      error_count = 0;
      check_total = 0;
      writes_done = 0;
      tests_run   = 0;
      repeat (4) @(negedge clk_i);
      reset = 1'b0;

      test_reset_state();
      test_lane_align();
      test_partial_strobes();
      test_back_pressure();
      test_random_stalls();

      $display("tests %0d, writes %0d, checks %0d, errors %0d",
               tests_run, writes_done, check_total, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: simulation ran past %0d ns", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- src.f
+incdir+design
+incdir+tests
design/wt_cache_pkg.sv
design/wt_write_buffer.sv
design/wt_write_channel.sv
design/wt_write_path.sv
tests/tb_wt_write_path.sv

//--- Makefile
# Verilator build and run of the write path testbench
# any variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_wt_write_path
RTL_TOP    ?= wt_write_path
FILELIST   ?= src.f
BUILD_DIR  ?= build
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

PASS_MSG   := Simulation finished: PASS
SOURCES    := $(wildcard design/*.sv design/*.svh tests/*.sv tests/*.svh)
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
